// File: src/i2sPkg.sv
package i2sPkg;

    // ----------------------------------------
    // bus widths
    // ----------------------------------------
    localparam int DataWidth  = 32;             // apb data and fifo frame width
    localparam int ChannelSel = 4;              // channel index lives in paddr[7:4]
    localparam int AddrWidth  = ChannelSel + 4; // index plus word offset plus byte bits

    // ----------------------------------------
    // address map
    // ----------------------------------------
    localparam logic [ChannelSel-1:0] GlobalChannel = ChannelSel'(15); // global irq register

    localparam logic [1:0] OffsetData   = 2'd0; // sample push, write only
    localparam logic [1:0] OffsetConfig = 2'd1; // four config bits
    localparam logic [1:0] OffsetStatus = 2'd2; // word count and full, read only

    // config register, sampleSize sits in bit 0 and soundIre in bit 3
    typedef struct packed {
        logic soundIre;   // half-level interrupt enable
        logic playback;   // 1 lets the transmitter pull frames
        logic stereoMode; // 0 is mono
        logic sampleSize; // 0 is 8 bit, 1 is 16 bit
    } audioConfigT;

endpackage

// File: src/channelBus.sv
`timescale 1ns/1ps

interface channelBus
    import i2sPkg::*;
#(
    parameter int FifoDepth = 64
);

    localparam int CountWidth = $clog2(FifoDepth + 1); // count must reach FifoDepth

    // host to channel
    logic [DataWidth-1:0]  wdata;        // shared write data
    logic                  dataLoadEn;   // one cycle fifo push
    logic                  configLoadEn; // one cycle config load

    // channel to host
    audioConfigT           cfg;          // current config bits
    logic [CountWidth-1:0] wordCount;    // fifo fill level
    logic                  full;         // fifo full flag

    modport host (
        output wdata,
        output dataLoadEn,
        output configLoadEn,
        input  cfg,
        input  wordCount,
        input  full
    );

    modport channel (
        input  wdata,
        input  dataLoadEn,
        input  configLoadEn,
        output cfg,
        output wordCount,
        output full
    );

endinterface

// File: src/sampleFifo.sv
`timescale 1ns/1ps

module sampleFifo
    import i2sPkg::*;
#(
    parameter int FifoDepth = 64
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             writeEn,   // push from the register block
    input  logic                             readReq,   // pop from the transmitter
    input  logic [DataWidth-1:0]             dataIn,
    output logic [DataWidth-1:0]             dataOut,   // head word, shown before the pop
    output logic [$clog2(FifoDepth+1)-1:0]   wordCount,
    output logic                             empty,
    output logic                             full
);

    localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;

    logic [DataWidth-1:0] mem [FifoDepth];
    logic [PtrWidth-1:0]  wrPtr;
    logic [PtrWidth-1:0]  rdPtr;

    // storage, no reset on the payload
    always_ff @(posedge clk) begin
        if (writeEn)
            mem[wrPtr] <= dataIn;
    end

    // pointers wrap at FifoDepth, depth need not be a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            wordCount <= '0;
        end else begin
            if (writeEn)
                wrPtr <= (wrPtr == PtrWidth'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            if (readReq)
                rdPtr <= (rdPtr == PtrWidth'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            case ({writeEn, readReq})
                2'b10:   wordCount <= wordCount + 1'b1;
                2'b01:   wordCount <= wordCount - 1'b1;
                default: wordCount <= wordCount; // idle or push and pop together
            endcase
        end
    end

    assign dataOut = mem[rdPtr];
    assign empty   = (wordCount == '0);
    assign full    = (wordCount == ($clog2(FifoDepth+1))'(FifoDepth));

    // the register block must turn away pushes once full
    assert property (@(posedge clk) disable iff (reset) writeEn |-> !full)
        else $error("sampleFifo: push while full");

    // the transmitter must only pop a word it saw at the wclk edge
    assert property (@(posedge clk) disable iff (reset) readReq |-> !empty)
        else $error("sampleFifo: pop while empty");

endmodule

// File: src/i2sTransmitter.sv
`timescale 1ns/1ps

module i2sTransmitter
    import i2sPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  audioConfigT          cfg,
    input  logic [DataWidth-1:0] sampleData, // fifo head word
    input  logic                 empty,
    input  logic                 wclk,       // from external i2s master
    input  logic                 bclk,       // from external i2s master
    output logic                 readReq,    // one pop per frame
    output logic                 sdout
);

    localparam int SlotWidth = 16; // widest sample, 8 bit samples are left justified

    logic [1:0]           wclkSync;  // two flop synchronizer
    logic [1:0]           bclkSync;
    logic                 wclkPrev;  // edge detector stage
    logic                 bclkPrev;
    logic                 wclkFall;
    logic                 wclkRise;
    logic                 bclkFall;
    logic                 frameTake; // pop decision for this frame
    logic [DataWidth-1:0] frameIn;   // head word or zeros on underrun
    logic [DataWidth-1:0] frameReg;  // held frame for the right slot
    logic [SlotWidth-1:0] shiftReg;

    // pick one slot out of a frame word, 8 bit samples padded with zeros
    function automatic logic [SlotWidth-1:0] slotOf(
        input logic [DataWidth-1:0] word,
        input audioConfigT          c,
        input logic                 rightSlot
    );
        logic [15:0] sample16;
        logic [7:0]  sample8;
        sample16 = (c.stereoMode && !rightSlot) ? word[31:16] : word[15:0]; // mono uses low half
        sample8  = (c.stereoMode && !rightSlot) ? word[15:8] : word[7:0];
        return c.sampleSize ? sample16 : {sample8, 8'd0};
    endfunction

    // ----------------------------------------
    // clock synchronizers and edge detection
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wclkSync <= '0;
            bclkSync <= '0;
            wclkPrev <= 1'b0;
            bclkPrev <= 1'b0;
        end else begin
            wclkSync <= {wclkSync[0], wclk};
            bclkSync <= {bclkSync[0], bclk};
            wclkPrev <= wclkSync[1];
            bclkPrev <= bclkSync[1];
        end
    end

    assign wclkFall  = wclkPrev & ~wclkSync[1]; // left slot starts
    assign wclkRise  = ~wclkPrev & wclkSync[1]; // right slot starts
    assign bclkFall  = bclkPrev & ~bclkSync[1]; // data changes here
    assign frameTake = wclkFall && cfg.playback && !empty;
    assign frameIn   = frameTake ? sampleData : '0;

    // ----------------------------------------
    // slot load and serial shift
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readReq  <= 1'b0;
            frameReg <= '0;
            shiftReg <= '0;
            sdout    <= 1'b0;
        end else begin
            readReq <= frameTake; // pop the word latched below
            if (bclkFall) begin
                sdout    <= shiftReg[SlotWidth-1];               // msb first
                shiftReg <= {shiftReg[SlotWidth-2:0], 1'b0};     // zeros past the sample
            end
            // a coincident bclk fall still sends the old lsb, giving the one bit delay
            if (wclkFall) begin
                frameReg <= frameIn;
                shiftReg <= slotOf(frameIn, cfg, 1'b0);
            end else if (wclkRise) begin
                shiftReg <= slotOf(frameReg, cfg, 1'b1);
            end
        end
    end

    // left slot boundaries line up with a bclk fall
    assert property (@(posedge clk) disable iff (reset) wclkFall |-> bclkFall)
        else $error("i2sTransmitter: wclk fall without a bclk fall");

endmodule

// File: src/i2sChannel.sv
`timescale 1ns/1ps

module i2sChannel
    import i2sPkg::*;
#(
    parameter int FifoDepth = 64
) (
    channelBus.channel bus,
    input  logic       clk,
    input  logic       reset,
    input  logic       wclk,
    input  logic       bclk,
    output logic       sdout,
    output logic       irqPulse  // one cycle, on the half level crossing
);

    localparam int CountWidth = $clog2(FifoDepth + 1);
    localparam int HalfLevel  = FifoDepth / 2;

    audioConfigT          cfgReg;
    logic [DataWidth-1:0] fifoHead;
    logic                 fifoEmpty;
    logic                 readReq;
    logic [CountWidth-1:0] prevCount; // count one cycle ago

    // config register
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            cfgReg <= '0;                             // 8 bit, mono, stopped, irq off
        else if (bus.configLoadEn)
            cfgReg <= audioConfigT'(bus.wdata[3:0]);
    end

    assign bus.cfg = cfgReg;

    // only a pop can move the count down through the level
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prevCount <= '0;
            irqPulse  <= 1'b0;
        end else begin
            prevCount <= bus.wordCount;
            irqPulse  <= cfgReg.soundIre
                      && (prevCount == CountWidth'(HalfLevel + 1))
                      && (bus.wordCount == CountWidth'(HalfLevel));
        end
    end

    sampleFifo #(.FifoDepth(FifoDepth)) fifo (
        .clk,
        .reset,
        .writeEn   (bus.dataLoadEn),
        .readReq,
        .dataIn    (bus.wdata),
        .dataOut   (fifoHead),
        .wordCount (bus.wordCount),
        .empty     (fifoEmpty),
        .full      (bus.full)
    );

    i2sTransmitter tx (
        .clk,
        .reset,
        .cfg        (cfgReg),
        .sampleData (fifoHead),
        .empty      (fifoEmpty),
        .wclk,
        .bclk,
        .readReq,
        .sdout
    );

endmodule

// File: src/apbAudioRegs.sv
`timescale 1ns/1ps

module apbAudioRegs
    import i2sPkg::*;
#(
    parameter int NumChannels = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [AddrWidth-1:0]   paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [DataWidth-1:0]   pwdata,
    output logic [DataWidth-1:0]   prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic [NumChannels-1:0] pending,    // from the irq collector
    output logic [NumChannels-1:0] clearMask,  // one cycle write-one-to-clear
    channelBus.host                chBus [NumChannels]
);

    logic [ChannelSel-1:0]  chIdx;
    logic [1:0]             offset;
    logic                   setup;
    logic                   access;
    logic                   writeOk;   // access cycle write that did not error
    logic                   chValid;
    logic                   isGlobal;
    logic                   selFull;
    logic                   errNext;
    logic [DataWidth-1:0]   readMux;
    logic [DataWidth-1:0]   cfgWord    [NumChannels];
    logic [DataWidth-1:0]   statusWord [NumChannels];
    logic [NumChannels-1:0] fullVec;

    // ----------------------------------------
    // address decode
    // ----------------------------------------
    assign chIdx    = paddr[7:4];
    assign offset   = paddr[3:2];
    assign setup    = psel && !penable;
    assign access   = psel && penable;
    assign chValid  = (chIdx < NumChannels);
    assign isGlobal = (chIdx == GlobalChannel);
    assign writeOk  = access && pwrite && !pslverr;
    assign pready   = penable;                   // no wait states

    // per channel load enables and readback words
    for (genvar g = 0; g < NumChannels; g++) begin : gChan
        assign cfgWord[g]    = DataWidth'(chBus[g].cfg);
        assign statusWord[g] = {15'd0, chBus[g].full, 16'(chBus[g].wordCount)};
        assign fullVec[g]    = chBus[g].full;

        assign chBus[g].wdata        = pwdata;
        assign chBus[g].dataLoadEn   = writeOk && (chIdx == g) && (offset == OffsetData);
        assign chBus[g].configLoadEn = writeOk && (chIdx == g) && (offset == OffsetConfig);
    end

    assign clearMask = (writeOk && isGlobal && offset == OffsetData) ?
                       pwdata[NumChannels-1:0] : '0;

    // ----------------------------------------
    // read mux and error check
    // ----------------------------------------
    always_comb begin
        readMux = '0;
        selFull = 1'b0;
        for (int c = 0; c < NumChannels; c++) begin
            if (chIdx == c) begin
                selFull = fullVec[c];
                if (offset == OffsetConfig)
                    readMux = cfgWord[c];
                else if (offset == OffsetStatus)
                    readMux = statusWord[c];
            end
        end
        if (isGlobal && offset == OffsetData)
            readMux = DataWidth'(pending);            // pending bits in the low end
    end

    assign errNext = (!chValid && !isGlobal)
                  || (pwrite && offset == OffsetStatus)
                  || (pwrite && offset == OffsetData && selFull);

    // sampled in setup, presented in the access cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pslverr <= 1'b0;
            prdata  <= '0;
        end else begin
            pslverr <= setup && errNext;
            prdata  <= (setup && !pwrite && !errNext) ? readMux : '0;
        end
    end

    // an error only ever shows in the access half of a proper transfer
    assert property (@(posedge clk) disable iff (reset)
        pslverr |-> access && $past(setup))
        else $error("apbAudioRegs: pslverr outside an access cycle");

endmodule

// File: src/irqCollector.sv
`timescale 1ns/1ps

module irqCollector #(
    parameter int NumChannels = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [NumChannels-1:0] irqPulse,   // one cycle per channel
    input  logic [NumChannels-1:0] clearMask,  // write-one-to-clear
    output logic [NumChannels-1:0] pending,
    output logic                   irq
);

    logic [NumChannels-1:0] pendingNext;

    // a new pulse beats a clear of the same bit
    assign pendingNext = (pending & ~clearMask) | irqPulse;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending <= '0;
            irq     <= 1'b0;
        end else begin
            pending <= pendingNext;
            irq     <= |pendingNext; // rises with the pending bit
        end
    end

endmodule

// File: src/i2sPlaybackArray.sv
`timescale 1ns/1ps

module i2sPlaybackArray
    import i2sPkg::*;
#(
    parameter int NumChannels = 4,
    parameter int FifoDepth   = 64
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [AddrWidth-1:0]   paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [DataWidth-1:0]   pwdata,
    output logic [DataWidth-1:0]   prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   irq,
    input  logic                   wclk,   // shared by all channels
    input  logic                   bclk,
    output logic [NumChannels-1:0] sdout
);

    logic [NumChannels-1:0] irqPulse;
    logic [NumChannels-1:0] pending;
    logic [NumChannels-1:0] clearMask;

    channelBus #(.FifoDepth(FifoDepth)) chBus [NumChannels] ();

    apbAudioRegs #(.NumChannels(NumChannels)) regs (
        .clk, .reset,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .pending, .clearMask,
        .chBus
    );

    for (genvar g = 0; g < NumChannels; g++) begin : gChannel
        i2sChannel #(.FifoDepth(FifoDepth)) channel (
            .bus (chBus[g]), .clk, .reset, .wclk, .bclk,
            .sdout (sdout[g]), .irqPulse (irqPulse[g])
        );
    end

    irqCollector #(.NumChannels(NumChannels)) irqs (
        .clk, .reset, .irqPulse, .clearMask, .pending, .irq
    );

endmodule

// File: bench/i2sPlaybackArrayTb.sv
`timescale 1ns/1ps

module i2sPlaybackArrayTb
    import i2sPkg::*;
();

    localparam int NumChannels  = 4;
    localparam int FifoDepth    = 64;
    localparam int HalfLevel    = FifoDepth / 2;
    localparam int BclkHalf     = 8;   // clk cycles per bclk phase
    localparam int SlotBits     = 16;  // bclk periods per wclk phase
    localparam int PlayFrames   = 6;
    localparam int OffFrames    = 4;
    localparam int PushedFrames = 4 * PlayFrames + OffFrames + FifoDepth + 2 * (HalfLevel + 2);
    localparam longint TimeoutNs = 2 * PushedFrames * 64 * 16 * 20;

    logic                   clk;
    logic                   reset;
    logic [AddrWidth-1:0]   paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [DataWidth-1:0]   pwdata;
    logic [DataWidth-1:0]   prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   irq;
    logic                   wclk;
    logic                   bclk;
    logic [NumChannels-1:0] sdout;

    integer      seed;
    int          errorCount;
    int          checkCount;
    int          testNum;
    int          testStartErrors;
    int          bitCount;         // bclk falls in the current wclk phase
    int          monChannel;       // channel whose sdout is captured
    int          framesSeen;
    int          framesWanted;
    bit          capturing;
    logic [31:0] expectedQ [$];    // {left, right} per pushed frame
    logic [31:0] capFrame;
    logic [31:0] expFrame;
    logic [15:0] shiftIn;
    logic [15:0] leftSlot;
    logic        lastWclk;
    event        frameDone;

    i2sPlaybackArray #(.NumChannels(NumChannels), .FifoDepth(FifoDepth)) uut (
        .clk, .reset,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .irq, .wclk, .bclk, .sdout
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // ----------------------------------------
    // external i2s master
    // ----------------------------------------
    initial begin
        bclk     = 1'b1;
        wclk     = 1'b1;
        bitCount = 0;
        forever begin
            repeat (BclkHalf) @(posedge clk);
            #2;
            bclk = ~bclk;
            if (!bclk) begin                 // wclk moves on a bclk fall
                bitCount = bitCount + 1;
                if (bitCount == SlotBits) begin
                    bitCount = 0;
                    wclk     = ~wclk;
                end
            end
        end
    end

    // serial capture, a slot ends one bclk after the wclk edge
    always @(posedge bclk) begin
        shiftIn = {shiftIn[14:0], sdout[monChannel]};
        if (wclk !== lastWclk) begin
            if (!lastWclk) begin
                leftSlot = shiftIn;                     // played while wclk was low
            end else if (capturing) begin
                capFrame = {leftSlot, shiftIn};
                -> frameDone;
            end
        end
        lastWclk = wclk;
    end

    // compare captured frames in push order, zeros once the queue runs dry
    initial begin
        forever begin
            @(frameDone);
            expFrame = (expectedQ.size() > 0) ? expectedQ.pop_front() : 32'd0;
            checkValue(capFrame, expFrame,
                       $sformatf("channel %0d frame %0d slots", monChannel, framesSeen));
            framesSeen = framesSeen + 1;
        end
    end

    initial begin
        #(TimeoutNs);
        $display("watchdog: run did not finish within %0d ns", TimeoutNs);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [31:0] expectedSlots(input logic [31:0] word,
                                                  input logic [3:0]  cfgBits);
        logic [15:0] leftVal;
        logic [15:0] rightVal;
        if (cfgBits[0]) begin                                   // 16 bit samples
            rightVal = word[15:0];
            leftVal  = cfgBits[1] ? word[31:16] : word[15:0];
        end else begin                                          // 8 bit, zeros after the lsb
            rightVal = {word[7:0], 8'h00};
            leftVal  = cfgBits[1] ? {word[15:8], 8'h00} : {word[7:0], 8'h00};
        end
        return {leftVal, rightVal};
    endfunction

    function automatic logic [AddrWidth-1:0] regAddr(input int ch, input logic [1:0] off);
        return {4'(ch), off, 2'b00};
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
        checkCount = checkCount + 1;
        if (actual !== expected) begin
            errorCount = errorCount + 1;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, msg, actual, expected);
        end
    endtask

    task automatic apbWrite(input logic [AddrWidth-1:0] addr, input logic [31:0] data,
                            output logic err);
        @(posedge clk);
        #2;
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        #2;
        err = pslverr;   // registered, steady through the access cycle
        checkValue(pready, 1, "pready in write access cycle");
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbRead(input logic [AddrWidth-1:0] addr, output logic [31:0] data,
                           output logic err);
        @(posedge clk);
        #2;
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        #2;
        data = prdata;
        err  = pslverr;
        checkValue(pready, 1, "pready in read access cycle");
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // start counting frames at the first left slot after the next wclk fall
    task automatic armCapture(input int frames);
        @(negedge wclk);
        @(posedge bclk);
        #1;
        framesSeen   = 0;
        framesWanted = frames;
        capturing    = 1'b1;
        wait (framesSeen >= framesWanted);
        capturing = 1'b0;
    endtask

    task automatic playFrames(input int ch, input logic [3:0] cfgBits, input int frames);
        logic [31:0] word;
        logic [31:0] rdata;
        logic        err;
        monChannel = ch;
        apbWrite(regAddr(ch, OffsetConfig), {28'd0, cfgBits & 4'b1011}, err); // stopped
        for (int i = 0; i < frames; i++) begin
            word = $random(seed);
            expectedQ.push_back(expectedSlots(word, cfgBits));
            apbWrite(regAddr(ch, OffsetData), word, err);
            checkValue(err, 0, "push accepted");
        end
        @(posedge wclk);                                          // right slot, frame is idle
        apbWrite(regAddr(ch, OffsetConfig), {28'd0, cfgBits | 4'b0100}, err);
        armCapture(frames + 2);                                   // two underrun frames
        apbWrite(regAddr(ch, OffsetConfig), {28'd0, cfgBits & 4'b1011}, err);
        apbRead(regAddr(ch, OffsetStatus), rdata, err);
        checkValue(rdata, 0, "fifo drained by playback");
    endtask

    task automatic finishTest(input string name);
        testNum = testNum + 1;
        $display("test %0d %s: %s", testNum, name,
                 (errorCount == testStartErrors) ? "passed" : "failed");
        testStartErrors = errorCount;
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        logic [31:0] rdata;
        logic        err;
        logic [3:0]  cfgVal [NumChannels];
        int          count;
        seed            = 32'h8402b33d;
        errorCount      = 0;
        checkCount      = 0;
        testNum         = 0;
        testStartErrors = 0;
        monChannel      = 0;
        capturing       = 1'b0;
        framesSeen      = 0;
        framesWanted    = 0;
        shiftIn         = '0;
        leftSlot        = '0;
        lastWclk        = 1'b1;
        paddr           = '0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        pwdata          = '0;
        reset           = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        for (int ch = 0; ch < NumChannels; ch++) begin
            apbRead(regAddr(ch, OffsetConfig), rdata, err);
            checkValue(rdata, 0, "config after reset");
            apbRead(regAddr(ch, OffsetStatus), rdata, err);
            checkValue(rdata, 0, "status after reset");
        end
        apbRead(regAddr(GlobalChannel, OffsetData), rdata, err);
        checkValue(rdata, 0, "pending after reset");
        checkValue(irq, 0, "irq after reset");
        checkValue(sdout, 0, "sdout after reset");
        finishTest("reset values");

        for (int ch = 0; ch < NumChannels; ch++) begin
            cfgVal[ch] = 4'($random(seed));
            apbWrite(regAddr(ch, OffsetConfig), {28'd0, cfgVal[ch]}, err);
            checkValue(err, 0, "config write accepted");
        end
        for (int ch = 0; ch < NumChannels; ch++) begin
            apbRead(regAddr(ch, OffsetConfig), rdata, err);
            checkValue(rdata, {28'd0, cfgVal[ch]}, "config readback");
        end
        apbWrite(regAddr(5, OffsetConfig), 32'hF, err);
        checkValue(err, 1, "write to channel 5 errors");
        apbRead(regAddr(5, OffsetConfig), rdata, err);
        checkValue(err, 1, "read of channel 5 errors");
        apbWrite(regAddr(0, OffsetStatus), 32'hFFFF, err);
        checkValue(err, 1, "status write errors");
        apbRead(regAddr(0, OffsetStatus), rdata, err);
        checkValue(rdata, 0, "status unchanged by errored write");
        for (int ch = 0; ch < NumChannels; ch++) begin
            apbRead(regAddr(ch, OffsetConfig), rdata, err);
            checkValue(rdata, {28'd0, cfgVal[ch]}, "config unchanged by errored writes");
        end
        for (int ch = 0; ch < NumChannels; ch++)
            apbWrite(regAddr(ch, OffsetConfig), 32'd0, err);
        finishTest("config access");

        playFrames(0, 4'b0011, PlayFrames);   // 16 bit stereo
        playFrames(2, 4'b0010, PlayFrames);   // 8 bit stereo
        finishTest("stereo playback");

        playFrames(1, 4'b0001, PlayFrames);   // 16 bit mono
        playFrames(3, 4'b0000, PlayFrames);   // 8 bit mono
        monChannel = 1;
        apbWrite(regAddr(1, OffsetConfig), 32'h3, err);           // playback off
        for (int i = 0; i < OffFrames; i++)
            apbWrite(regAddr(1, OffsetData), $random(seed), err);
        armCapture(2);                                            // silence expected
        apbRead(regAddr(1, OffsetStatus), rdata, err);
        checkValue(rdata, OffFrames, "count held with playback off");
        finishTest("mono and stopped playback");

        for (int i = 1; i <= FifoDepth; i++) begin
            apbWrite(regAddr(3, OffsetData), $random(seed), err);
            checkValue(err, 0, "fill push accepted");
            apbRead(regAddr(3, OffsetStatus), rdata, err);
            checkValue(rdata, (i == FifoDepth) ? (32'h1_0000 | i) : i, "status while filling");
        end
        apbWrite(regAddr(3, OffsetData), $random(seed), err);
        checkValue(err, 1, "push into full fifo errors");
        apbRead(regAddr(3, OffsetStatus), rdata, err);
        checkValue(rdata, 32'h1_0000 | FifoDepth, "status unchanged after overflow");
        finishTest("fifo fill");

        apbRead(regAddr(1, OffsetStatus), rdata, err);
        count = rdata[15:0];
        for (int i = count; i < HalfLevel + 2; i++)
            apbWrite(regAddr(1, OffsetData), $random(seed), err);
        apbWrite(regAddr(1, OffsetConfig), 32'hD, err);           // 16 bit, playing, irq on
        wait (irq === 1'b1);
        apbRead(regAddr(GlobalChannel, OffsetData), rdata, err);
        checkValue(rdata, 32'h2, "channel 1 pending");
        apbWrite(regAddr(1, OffsetConfig), 32'h9, err);
        apbWrite(regAddr(GlobalChannel, OffsetData), 32'h2, err); // write one to clear
        apbRead(regAddr(GlobalChannel, OffsetData), rdata, err);
        checkValue(rdata, 0, "pending cleared");
        checkValue(irq, 0, "irq cleared");

        apbRead(regAddr(1, OffsetStatus), rdata, err);
        count = rdata[15:0];
        for (int i = count; i < HalfLevel + 2; i++)
            apbWrite(regAddr(1, OffsetData), $random(seed), err);
        apbWrite(regAddr(1, OffsetConfig), 32'h5, err);           // playing, irq off
        repeat (4) @(negedge wclk);
        apbWrite(regAddr(1, OffsetConfig), 32'h1, err);
        apbRead(regAddr(1, OffsetStatus), rdata, err);
        checkValue(rdata[15:0] < HalfLevel, 1, "fifo drained past half level");
        apbRead(regAddr(GlobalChannel, OffsetData), rdata, err);
        checkValue(rdata, 0, "no pending with irq disabled");
        checkValue(irq, 0, "irq stays low");
        finishTest("half level interrupt");

        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: i2sPlaybackArray.f
src/i2sPkg.sv
src/channelBus.sv
src/sampleFifo.sv
src/i2sTransmitter.sv
src/i2sChannel.sv
src/apbAudioRegs.sv
src/irqCollector.sv
src/i2sPlaybackArray.sv
bench/i2sPlaybackArrayTb.sv

// File: Bender.yml
package:
  name: i2sPlaybackArray

sources:
  - src/i2sPkg.sv
  - src/channelBus.sv
  - src/sampleFifo.sv
  - src/i2sTransmitter.sv
  - src/i2sChannel.sv
  - src/apbAudioRegs.sv
  - src/irqCollector.sv
  - src/i2sPlaybackArray.sv
  - target: test
    files:
      - bench/i2sPlaybackArrayTb.sv
